// File: build.f
+incdir+.
fcs_pkg.sv
fcs_apb_regs.sv
fcs_beat_fifo.sv
crc32_eth_x64.sv
fcs_ctrl.sv
fcs_top.sv
tb_fcs_top.sv

// File: crc32_eth_x64.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcs_defs.svh"

module crc32_eth_x64 (
	input  wire        clk,
	input  wire        reset,
	input  wire        init,
	input  wire        valid,
	input  wire [63:0] din,
	input  wire [3:0]  din_len,
	output logic [31:0] crc_out
);

	// Ethernet generator polynomial, normal form
	localparam logic [31:0] POLY = 32'h04C1_1DB7;

	logic [31:0] crc;
	logic [31:0] crc_next;

	// Fold up to eight left aligned bytes into the CRC
	function automatic logic [31:0] crc_fold(
		input logic [31:0] c_in,
		input logic [63:0] d,
		input logic [3:0]  n
	);
		logic [31:0] c;
		logic [7:0]  b;
		logic        fb;
		c = c_in;
		for (int i = 0; i < 8; i++) begin
			if (i < n) begin
				// Byte 0 first
				b = d[(7-i)*8 +: 8];
				// Each byte goes in LSB first as on the wire
				for (int j = 0; j < 8; j++) begin
					fb = b[j] ^ c[31];
					c  = {c[30:0], 1'b0};
					if (fb)
						c = c ^ POLY;
				end
			end
		end
		return c;
	endfunction

	// Zero length leaves crc unchanged
	assign crc_next = crc_fold(crc, din, din_len);

	always_ff @(posedge clk) begin
		if (reset || init)
			crc <= `FCS_CRC_SEED;
		else if (valid)
			crc <= crc_next;
	end

	// Complement and reverse the bits of each byte in place
	// Byte 3 of the output is the first FCS byte sent
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			for (int m = 0; m < 8; m++)
				crc_out[k*8 + m] = ~crc[k*8 + 7 - m];
		end
	end

endmodule

`default_nettype wire

// File: fcs_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcs_defs.svh"

module fcs_apb_regs (
	input  wire                     clk,
	input  wire                     reset,
	input  wire fcs_pkg::apb_req_t  apb_req,
	output fcs_pkg::apb_rsp_t       apb_rsp,
	output logic                    push,
	output fcs_pkg::fcs_beat_t      push_beat,
	input  wire                     fifo_full,
	input  wire [3:0]               fifo_level,
	output logic                    cmd_valid,
	output fcs_pkg::fcs_cmd_e       cmd,
	output logic [31:0]             fcs_expect,
	input  wire fcs_pkg::fcs_status_t status,
	input  wire [31:0]              result
);
	import fcs_pkg::*;

	// Staged beat words
	logic [31:0] data_hi;
	logic [31:0] data_lo;

	// Decoded access
	logic access;
	logic mapped;
	logic ro_write;
	logic push_bad;
	logic err;
	logic wr_ok;

	// ACCESS phase of a transfer
	assign access = apb_req.psel & apb_req.penable;

	// Address map check
	always_comb begin
		case (apb_req.paddr)
			`FCS_ADDR_CTRL, `FCS_ADDR_DATA_HI, `FCS_ADDR_DATA_LO, `FCS_ADDR_PUSH,
			`FCS_ADDR_STATUS, `FCS_ADDR_RESULT, `FCS_ADDR_EXPECT: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// STATUS and RESULT are read only
	assign ro_write = apb_req.pwrite &
		((apb_req.paddr == `FCS_ADDR_STATUS) | (apb_req.paddr == `FCS_ADDR_RESULT));

	// Oversized beat or no room left in the FIFO
	assign push_bad = apb_req.pwrite & (apb_req.paddr == `FCS_ADDR_PUSH) &
		((apb_req.pwdata[3:0] > 4'd8) | fifo_full);

	assign err   = access & (~mapped | ro_write | push_bad);
	assign wr_ok = access & apb_req.pwrite & ~err;

	// Enqueue lands on the edge that ends ACCESS
	assign push = wr_ok & (apb_req.paddr == `FCS_ADDR_PUSH);

	assign push_beat.data = {data_hi, data_lo};
	assign push_beat.len  = apb_req.pwdata[3:0];
	assign push_beat.last = apb_req.pwdata[4];

	// Control registers
	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_valid  <= 1'b0;
			cmd        <= FCS_CMD_NOP;
			fcs_expect <= 32'd0;
		end else begin
			// One cycle command pulse after the CTRL write
			cmd_valid <= wr_ok & (apb_req.paddr == `FCS_ADDR_CTRL);
			if (wr_ok & (apb_req.paddr == `FCS_ADDR_CTRL))
				cmd <= fcs_cmd_e'(apb_req.pwdata[1:0]);
			if (wr_ok & (apb_req.paddr == `FCS_ADDR_EXPECT))
				fcs_expect <= apb_req.pwdata;
		end
	end

	// Beat staging words
	always_ff @(posedge clk) begin
		if (wr_ok & (apb_req.paddr == `FCS_ADDR_DATA_HI))
			data_hi <= apb_req.pwdata;
		if (wr_ok & (apb_req.paddr == `FCS_ADDR_DATA_LO))
			data_lo <= apb_req.pwdata;
	end

	// Read mux
	// Write only registers read back as zero
	always_comb begin
		apb_rsp.prdata = 32'd0;
		if (access & ~apb_req.pwrite) begin
			case (apb_req.paddr)
				`FCS_ADDR_DATA_HI: apb_rsp.prdata = data_hi;
				`FCS_ADDR_DATA_LO: apb_rsp.prdata = data_lo;
				`FCS_ADDR_STATUS:
					apb_rsp.prdata = {20'd0, fifo_level, 5'd0,
						status.fcs_ok, status.done, status.busy};
				`FCS_ADDR_RESULT:  apb_rsp.prdata = result;
				`FCS_ADDR_EXPECT:  apb_rsp.prdata = fcs_expect;
				default:           apb_rsp.prdata = 32'd0;
			endcase
		end
	end

	// No wait states
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = err;

endmodule

`default_nettype wire

// File: fcs_beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcs_defs.svh"

module fcs_beat_fifo (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      push,
	input  wire fcs_pkg::fcs_beat_t  push_beat,
	input  wire                      pop,
	input  wire                      flush,
	output fcs_pkg::fcs_beat_t       head,
	output logic                     empty,
	output logic                     full,
	output logic [3:0]               level
);
	import fcs_pkg::*;

	localparam int PTR_W = $clog2(`FCS_FIFO_DEPTH);

	// Beat storage
	fcs_beat_t mem [`FCS_FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [3:0]       count;

	// Storage write
	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_beat;
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= 4'd0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Level tracks net change
			case ({push, pop})
				2'b10:   count <= count + 4'd1;
				2'b01:   count <= count - 4'd1;
				default: count <= count;
			endcase
		end
	end

	// Show ahead head beat
	assign head  = mem[rd_ptr];
	assign empty = (count == 4'd0);
	assign full  = (count == 4'(`FCS_FIFO_DEPTH));
	assign level = count;

endmodule

`default_nettype wire

// File: fcs_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fcs_ctrl (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      cmd_valid,
	input  wire fcs_pkg::fcs_cmd_e   cmd,
	input  wire fcs_pkg::fcs_beat_t  head,
	input  wire                      empty,
	output logic                     pop,
	output logic                     flush,
	output logic                     crc_init,
	output logic                     crc_valid,
	output logic [63:0]              crc_data,
	output logic [3:0]               crc_len,
	input  wire [31:0]               crc_in,
	input  wire [31:0]               fcs_expect,
	output fcs_pkg::fcs_status_t     status,
	output logic [31:0]              result
);
	import fcs_pkg::*;

	fcs_state_e state;
	fcs_state_e state_next;

	logic start_cmd;
	logic abort_cmd;
	logic fcs_ok;

	// Decoded command pulses
	assign start_cmd = cmd_valid & (cmd == FCS_CMD_START);
	assign abort_cmd = cmd_valid & (cmd == FCS_CMD_ABORT);

	// Seed the engine on the same edge that enters RUN
	assign crc_init = start_cmd;

	// Abort drops every queued beat
	assign flush = abort_cmd;

	// Pop one beat per cycle in RUN
	// A command in the same cycle takes priority over the pop
	assign pop = (state == FCS_RUN) & ~empty & ~start_cmd & ~abort_cmd;

	// Popped beat goes straight to the engine
	assign crc_valid = pop;
	assign crc_data  = head.data;
	assign crc_len   = head.len;

	always_comb begin
		state_next = state;
		case (state)
			FCS_IDLE:   state_next = FCS_IDLE;
			FCS_RUN: begin
				// Last beat of the frame ends the run
				if (pop && head.last)
					state_next = FCS_FINISH;
			end
			// Engine output is settled one cycle after the last beat
			FCS_FINISH: state_next = FCS_DONE;
			FCS_DONE:   state_next = FCS_DONE;
			default:    state_next = FCS_IDLE;
		endcase
		// Commands override from any state
		if (abort_cmd)
			state_next = FCS_IDLE;
		else if (start_cmd)
			state_next = FCS_RUN;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= FCS_IDLE;
			fcs_ok <= 1'b0;
			result <= 32'd0;
		end else begin
			state <= state_next;
			// Compare flag is stale once a new frame starts
			if (start_cmd || abort_cmd)
				fcs_ok <= 1'b0;
			else if (state == FCS_FINISH) begin
				// Capture once per frame
				result <= crc_in;
				fcs_ok <= (crc_in == fcs_expect);
			end
		end
	end

	assign status.busy   = (state == FCS_RUN) | (state == FCS_FINISH);
	assign status.done   = (state == FCS_DONE);
	assign status.fcs_ok = fcs_ok;

endmodule

`default_nettype wire

// File: fcs_defs.svh
`ifndef FCS_DEFS_SVH
`define FCS_DEFS_SVH

// Beat FIFO depth, a power of two that fits the 4 bit level field
`define FCS_FIFO_DEPTH 8

// APB register offsets
`define FCS_ADDR_CTRL    8'h00
`define FCS_ADDR_DATA_HI 8'h04
`define FCS_ADDR_DATA_LO 8'h08
`define FCS_ADDR_PUSH    8'h0C
`define FCS_ADDR_STATUS  8'h10
`define FCS_ADDR_RESULT  8'h14
`define FCS_ADDR_EXPECT  8'h18

// Initial CRC register value
// Same as complementing the first 32 bits of the frame
`define FCS_CRC_SEED 32'hFFFF_FFFF

`endif

// File: fcs_pkg.sv
`default_nettype none

package fcs_pkg;

	// APB request as seen by the slave
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// APB response back to the master
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// One frame beat
	// Byte 0 sits in data[63:56]
	typedef struct packed {
		logic [63:0] data;
		logic [3:0]  len;
		logic        last;
	} fcs_beat_t;

	// CTRL command opcodes
	typedef enum logic [1:0] {
		FCS_CMD_NOP   = 2'd0,
		FCS_CMD_START = 2'd1,
		FCS_CMD_ABORT = 2'd2
	} fcs_cmd_e;

	// Frame controller states
	typedef enum logic [1:0] {
		FCS_IDLE   = 2'd0,
		FCS_RUN    = 2'd1,
		FCS_FINISH = 2'd2,
		FCS_DONE   = 2'd3
	} fcs_state_e;

	// Controller status flags for STATUS
	typedef struct packed {
		logic busy;
		logic done;
		logic fcs_ok;
	} fcs_status_t;

endpackage

`default_nettype wire

// File: fcs_top.sv
`timescale 1ns/1ps
`default_nettype none

module fcs_top (
	input  wire                     clk,
	input  wire                     reset,
	input  wire fcs_pkg::apb_req_t  apb_req,
	output fcs_pkg::apb_rsp_t       apb_rsp
);
	import fcs_pkg::*;

	// Register block to FIFO
	logic        push;
	fcs_beat_t   push_beat;

	// FIFO outputs
	fcs_beat_t   head;
	logic        empty;
	logic        full;
	logic [3:0]  level;

	// Command path and status
	logic        cmd_valid;
	fcs_cmd_e    cmd;
	logic [31:0] fcs_expect;
	fcs_status_t status;
	logic [31:0] result;

	// Controller to FIFO and engine
	logic        pop;
	logic        flush;
	logic        crc_init;
	logic        crc_valid;
	logic [63:0] crc_data;
	logic [3:0]  crc_len;
	logic [31:0] crc_out;

	fcs_apb_regs regs0 (
		.clk        (clk),
		.reset      (reset),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.push       (push),
		.push_beat  (push_beat),
		.fifo_full  (full),
		.fifo_level (level),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.fcs_expect (fcs_expect),
		.status     (status),
		.result     (result)
	);

	fcs_beat_fifo fifo0 (
		.clk       (clk),
		.reset     (reset),
		.push      (push),
		.push_beat (push_beat),
		.pop       (pop),
		.flush     (flush),
		.head      (head),
		.empty     (empty),
		.full      (full),
		.level     (level)
	);

	crc32_eth_x64 crc0 (
		.clk     (clk),
		.reset   (reset),
		.init    (crc_init),
		.valid   (crc_valid),
		.din     (crc_data),
		.din_len (crc_len),
		.crc_out (crc_out)
	);

	fcs_ctrl ctrl0 (
		.clk        (clk),
		.reset      (reset),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.head       (head),
		.empty      (empty),
		.pop        (pop),
		.flush      (flush),
		.crc_init   (crc_init),
		.crc_valid  (crc_valid),
		.crc_data   (crc_data),
		.crc_len    (crc_len),
		.crc_in     (crc_out),
		.fcs_expect (fcs_expect),
		.status     (status),
		.result     (result)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the FCS unit testbench with Verilator
# The run counts as passed only when the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_fcs_top -o sim_fcs &&
./obj_dir/sim_fcs | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run_sim: run passed" ||
{ echo "run_sim: run failed"; exit 1; }

// File: tb_fcs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcs_defs.svh"

module tb_fcs_top;
	import fcs_pkg::*;

	// Longest sequence is near 4000 cycles with three APB cycles per transfer
	localparam int CYCLE_LIMIT = 20000;

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	// Frame bytes shared by stimulus and reference model
	logic [7:0]  frame_buf [0:255];
	logic [31:0] lfsr;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;

	// Hand-off to the compare process
	string       cmp_name;
	logic [31:0] cmp_got;
	logic [31:0] cmp_exp;
	logic        cmp_pending = 1'b0;

	fcs_top dut0 (
		.clk     (clk),
		.reset   (reset),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Compare process takes one value per request
	always begin
		wait (cmp_pending);
		checks = checks + 1;
		if (cmp_got !== cmp_exp) begin
			$display("MISMATCH %s: got 0x%08h expected 0x%08h", cmp_name, cmp_got, cmp_exp);
			errors = errors + 1;
		end
		cmp_pending = 1'b0;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		cmp_name = name;
		cmp_got = got;
		cmp_exp = exp;
		cmp_pending = 1'b1;
		wait (!cmp_pending);
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Reflected CRC-32 over frame_buf with bytes swapped to match RESULT
	function automatic logic [31:0] crc_ref(input int n);
		logic [31:0] c;
		c = 32'hFFFF_FFFF;
		for (int i = 0; i < n; i++) begin
			c = c ^ {24'd0, frame_buf[i]};
			for (int j = 0; j < 8; j++)
				c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
		end
		c = ~c;
		return {c[7:0], c[15:8], c[23:16], c[31:24]};
	endfunction

	// SETUP then ACCESS with the response sampled mid ACCESS
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= wr;
		apb_req.paddr <= addr;
		apb_req.pwdata <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// No wait states on this slave
		check_value("pready", {31'd0, apb_rsp.pready}, 32'd1);
		@(posedge clk);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] unused;
		logic err;
		apb_xfer(1'b1, addr, data, unused, err);
		check_value("pslverr", {31'd0, err}, {31'd0, exp_err});
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, data, err);
		check_value("pslverr", {31'd0, err}, {31'd0, exp_err});
	endtask

	// Staged words plus PUSH with the error flag returned to the caller
	task automatic push_beat(input logic [63:0] data, input logic [3:0] len, input logic last,
		output logic err);
		logic [31:0] unused;
		write_reg(`FCS_ADDR_DATA_HI, data[63:32], 1'b0);
		write_reg(`FCS_ADDR_DATA_LO, data[31:0], 1'b0);
		apb_xfer(1'b1, `FCS_ADDR_PUSH, {27'd0, last, len}, unused, err);
	endtask

	// Left aligned beat from frame_buf
	function automatic logic [63:0] beat_data(input int pos, input int len);
		logic [63:0] d;
		d = '0;
		for (int i = 0; i < len; i++)
			d[(7-i)*8 +: 8] = frame_buf[pos+i];
		return d;
	endfunction

	task automatic fill_frame(input int start, input int n);
		logic [31:0] r;
		for (int i = start; i < start + n; i++) begin
			rand_bits(8, r);
			frame_buf[i] = r[7:0];
		end
	endtask

	// Full beats of 8 or random lengths 0 to 8
	task automatic send_frame(input int n, input logic rand_split);
		int pos;
		int len;
		logic [31:0] r;
		logic [31:0] st;
		logic err;
		pos = 0;
		while (pos < n) begin
			len = 8;
			if (rand_split) begin
				rand_bits(4, r);
				len = int'(r % 32'd9);
			end
			if (len > n - pos)
				len = n - pos;
			push_beat(beat_data(pos, len), 4'(len), (pos + len) == n, err);
			// On a full FIFO poll the level and retry once there is room
			while (err) begin
				read_reg(`FCS_ADDR_STATUS, 1'b0, st);
				if (int'(st[11:8]) < `FCS_FIFO_DEPTH)
					push_beat(beat_data(pos, len), 4'(len), (pos + len) == n, err);
			end
			pos = pos + len;
		end
	endtask

	task automatic wait_done(output logic [31:0] st);
		st = '0;
		while (!st[1])
			read_reg(`FCS_ADDR_STATUS, 1'b0, st);
	endtask

	task automatic run_frame(input int n, input logic rand_split, input logic [31:0] exp_fcs,
		output logic [31:0] st, output logic [31:0] res);
		write_reg(`FCS_ADDR_EXPECT, exp_fcs, 1'b0);
		write_reg(`FCS_ADDR_CTRL, {30'd0, FCS_CMD_START}, 1'b0);
		send_frame(n, rand_split);
		wait_done(st);
		read_reg(`FCS_ADDR_RESULT, 1'b0, res);
	endtask

	task automatic start_test();
		test_start_errors = errors;
		tests_run = tests_run + 1;
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %0d %s: FAILED with %0d errors", tests_run, name,
				errors - test_start_errors);
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] st;
		logic [31:0] r;
		logic [31:0] exp_crc;
		logic err;
		int n;
		int len;
		clk = 1'b0;
		reset = 1'b1;
		apb_req = '0;
		lfsr = 32'd32;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Reset values, EXPECT readback, access errors
		start_test();
		read_reg(`FCS_ADDR_STATUS, 1'b0, rd);
		check_value("STATUS", rd, 32'd0);
		read_reg(`FCS_ADDR_RESULT, 1'b0, rd);
		check_value("RESULT", rd, 32'd0);
		for (int i = 0; i < 4; i++) begin
			rand_bits(32, r);
			write_reg(`FCS_ADDR_EXPECT, r, 1'b0);
			read_reg(`FCS_ADDR_EXPECT, 1'b0, rd);
			check_value("EXPECT", rd, r);
		end
		read_reg(8'h20, 1'b1, rd);
		write_reg(`FCS_ADDR_RESULT, 32'h1234_5678, 1'b1);
		read_reg(`FCS_ADDR_RESULT, 1'b0, rd);
		check_value("RESULT", rd, 32'd0);
		end_test("reset and registers");

		// ASCII 123456789 as beats of 8 and 1
		start_test();
		for (int i = 0; i < 9; i++)
			frame_buf[i] = 8'h31 + 8'(i);
		run_frame(9, 1'b0, 32'h2639_F4CB, st, rd);
		check_value("RESULT", rd, 32'h2639_F4CB);
		check_value("STATUS.fcs_ok", {31'd0, st[2]}, 32'd1);
		end_test("known vector");

		start_test();
		for (int f = 0; f < 20; f++) begin
			rand_bits(6, r);
			n = int'(r[5:0]) + 1;
			fill_frame(0, n);
			run_frame(n, 1'b1, 32'd0, st, rd);
			check_value("RESULT", rd, crc_ref(n));
		end
		end_test("random frames");

		// Same frame with a matching and then a corrupted EXPECT
		start_test();
		rand_bits(6, r);
		n = int'(r[5:0]) + 1;
		fill_frame(0, n);
		exp_crc = crc_ref(n);
		run_frame(n, 1'b1, exp_crc, st, rd);
		check_value("STATUS.fcs_ok", {31'd0, st[2]}, 32'd1);
		rand_bits(5, r);
		run_frame(n, 1'b1, exp_crc ^ (32'd1 << r[4:0]), st, rd);
		check_value("STATUS.fcs_ok", {31'd0, st[2]}, 32'd0);
		check_value("RESULT", rd, exp_crc);
		// Done holds after the RESULT read
		read_reg(`FCS_ADDR_STATUS, 1'b0, st);
		check_value("STATUS", st, 32'h0000_0002);
		end_test("compare flag");

		// Oversized push and then an idle FIFO filled past its depth
		start_test();
		write_reg(`FCS_ADDR_CTRL, {30'd0, FCS_CMD_ABORT}, 1'b0);
		write_reg(`FCS_ADDR_PUSH, 32'h0000_0009, 1'b1);
		read_reg(`FCS_ADDR_STATUS, 1'b0, rd);
		check_value("STATUS", rd, 32'd0);
		n = 0;
		for (int b = 0; b < `FCS_FIFO_DEPTH; b++) begin
			rand_bits(3, r);
			len = int'(r[2:0]) + 1;
			fill_frame(n, len);
			push_beat(beat_data(n, len), 4'(len), b == `FCS_FIFO_DEPTH - 1, err);
			check_value("pslverr", {31'd0, err}, 32'd0);
			n = n + len;
		end
		read_reg(`FCS_ADDR_STATUS, 1'b0, rd);
		check_value("STATUS", rd, 32'(`FCS_FIFO_DEPTH) << 8);
		push_beat(64'hDEAD_BEEF_0000_0000, 4'd4, 1'b0, err);
		check_value("pslverr", {31'd0, err}, 32'd1);
		read_reg(`FCS_ADDR_STATUS, 1'b0, rd);
		check_value("STATUS", rd, 32'(`FCS_FIFO_DEPTH) << 8);
		write_reg(`FCS_ADDR_EXPECT, crc_ref(n), 1'b0);
		write_reg(`FCS_ADDR_CTRL, {30'd0, FCS_CMD_START}, 1'b0);
		wait_done(st);
		check_value("STATUS", st, 32'h0000_0006);
		read_reg(`FCS_ADDR_RESULT, 1'b0, rd);
		check_value("RESULT", rd, crc_ref(n));
		end_test("back-pressure and errors");

		// ABORT drops a partial frame in the engine and the beats queued after it
		start_test();
		write_reg(`FCS_ADDR_CTRL, {30'd0, FCS_CMD_START}, 1'b0);
		for (int b = 0; b < 4; b++) begin
			if (b == 2) begin
				write_reg(`FCS_ADDR_CTRL, {30'd0, FCS_CMD_ABORT}, 1'b0);
			end
			rand_bits(32, r);
			rand_bits(32, exp_crc);
			push_beat({r, exp_crc}, 4'd8, 1'b0, err);
			check_value("pslverr", {31'd0, err}, 32'd0);
		end
		read_reg(`FCS_ADDR_STATUS, 1'b0, rd);
		check_value("STATUS", rd, 32'h0000_0200);
		write_reg(`FCS_ADDR_CTRL, {30'd0, FCS_CMD_ABORT}, 1'b0);
		read_reg(`FCS_ADDR_STATUS, 1'b0, rd);
		check_value("STATUS", rd, 32'd0);
		rand_bits(6, r);
		n = int'(r[5:0]) + 1;
		fill_frame(0, n);
		run_frame(n, 1'b1, crc_ref(n), st, rd);
		check_value("RESULT", rd, crc_ref(n));
		check_value("STATUS.fcs_ok", {31'd0, st[2]}, 32'd1);
		end_test("abort");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
